// File: gnn_arith_pkg.sv
package gnn_arith_pkg;

    // signed feature and weight word
    localparam int FV_W = 16;

    // products and running sums wrap at this width
    localparam int ACC_W = 32;

    // one SRAM line carries four lanes
    localparam int LINE_W = 4 * FV_W;

endpackage

// File: gnn_trace.txt
// columns: op address data, all hex
// op 1 write, 2 check result, 3 check status, 4 check register,
// op 5 wait for done, 6 end of test, 7 write held by a run, 0 end
// test 1: idle status and register readback
3 00 00000000
1 01 00001003
4 01 00001003
1 13 0000ABCD
4 13 0000ABCD
6 00 00000001
// test 2: one layer, four features, dot product 14
1 01 00000400
1 10 00000003
1 11 0000FFFE
1 12 00000005
1 13 00000007
1 40 00040002  1 41 0003FFFF
1 00 00000001
5 00 00000000
2 80 0000000E
3 00 00000002
6 00 00000002
// test 3: four layers, sixteen features, wrapping sums
1 01 00001003
1 10 00007FFF  1 11 00007FFF  1 12 00007FFF  1 13 00007FFF
1 14 00007FFF  1 15 00007FFF  1 16 00007FFF  1 17 00007FFF
1 18 00008000  1 19 00008000  1 1A 00008000  1 1B 00008000
1 1C 00000001  1 1D 0000FFFF  1 1E 00000002  1 1F 0000FFFE
1 40 7FFF7FFF  1 41 7FFF7FFF  1 42 7FFF7FFF  1 43 7FFF7FFF
1 44 80008000  1 45 80008000  1 46 00000000  1 47 00000000
1 48 00020001  1 49 00040003  1 4A 00000000  1 4B 00000000
1 4C 00000000  1 4D 00000000  1 4E 00060005  1 4F 0008FFF9
1 50 00000000  1 51 00000000  1 52 00000000  1 53 00000000
1 54 7FFF7FFF  1 55 7FFF7FFF  1 56 00000000  1 57 00000000
1 58 FFFFFFFF  1 59 FFFFFFFF  1 5A 00000000  1 5B 00000000
1 5C 00000000  1 5D 00000000  1 5E 00000003  1 5F 00000000
1 00 00000001
5 00 00000000
2 80 FFF80008
2 81 0004FFD7
2 82 00020000
2 83 FFFE0007
6 00 00000003
// test 4: weight write held until the run ends
1 00 00000001
3 00 00000001
7 5E 00000005
1 5F 00000000
5 00 00000000
2 83 FFFE0007
1 00 00000001
5 00 00000000
2 83 FFFE0009
6 00 00000004
// test 5: start while busy is ignored, next start clears done
1 00 00000001
3 00 00000001
1 00 00000001
5 00 00000000
2 80 FFF80008
2 81 0004FFD7
2 82 00020000
2 83 FFFE0009
3 00 00000002
1 00 00000001
3 00 00000001
5 00 00000000
6 00 00000005
0 00 00000000

// File: gnn_vertex_top.sv
module gnn_vertex_top
    import gnn_arith_pkg::*, gnn_wb_pkg::*;
#(
    parameter int MULT_PER_PE = 4,
    parameter int MAX_FV_NUM  = 16,
    parameter int MAX_LAYERS  = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [WB_AW-1:0] adr,
    input  logic [WB_DW-1:0] dat_w,
    output logic [WB_DW-1:0] dat_r,
    output logic             ack
);

    localparam int DEPTH   = MAX_LAYERS * MAX_FV_NUM / MULT_PER_PE;
    localparam int SRAM_AW = $clog2(DEPTH);
    localparam int LAYER_W = $clog2(MAX_LAYERS);
    localparam int FVN_W   = $clog2(MAX_FV_NUM) + 1;
    localparam int FI_W    = $clog2(MAX_FV_NUM);

    logic                             start;
    logic                             busy;
    logic                             done;
    logic [LAYER_W-1:0]               num_layers_m1;
    logic [FVN_W-1:0]                 num_fv;
    logic [MAX_FV_NUM-1:0][FV_W-1:0]  feat;
    logic [MAX_LAYERS-1:0][ACC_W-1:0] results;

    logic                             sram_we;
    logic [SRAM_AW-1:0]               sram_a;
    logic [LINE_W-1:0]                sram_d;
    logic                             cntl_cen;
    logic [SRAM_AW-1:0]               cntl_a;
    logic                             mem_cen;
    logic                             mem_wen;
    logic [SRAM_AW-1:0]               mem_a;
    logic [LINE_W-1:0]                q;

    logic                             lane_valid;
    logic [MULT_PER_PE-1:0][FV_W-1:0] lanes;
    logic [FI_W-1:0]                  fv_base;
    logic [LAYER_W-1:0]               layer;
    logic                             sol;
    logic                             eol;
    logic                             last;

    logic                             res_valid;
    logic [LAYER_W-1:0]               res_layer;
    logic [ACC_W-1:0]                 res_sum;
    logic                             res_last;

    // controller reads while busy, bus writes while idle
    assign mem_cen = busy ? cntl_cen : !sram_we;
    assign mem_wen = busy || !sram_we;
    assign mem_a   = busy ? cntl_a : sram_a;

    wb_cfg_slave #(
        .MULT_PER_PE (MULT_PER_PE),
        .MAX_FV_NUM  (MAX_FV_NUM),
        .MAX_LAYERS  (MAX_LAYERS)
    ) u_slave (
        .clk           (clk),
        .reset         (reset),
        .cyc           (cyc),
        .stb           (stb),
        .we            (we),
        .adr           (adr),
        .dat_w         (dat_w),
        .busy          (busy),
        .done          (done),
        .results       (results),
        .dat_r         (dat_r),
        .ack           (ack),
        .start         (start),
        .num_layers_m1 (num_layers_m1),
        .num_fv        (num_fv),
        .feat          (feat),
        .sram_we       (sram_we),
        .sram_a        (sram_a),
        .sram_d        (sram_d)
    );

    weight_sram #(
        .DEPTH (DEPTH)
    ) u_sram (
        .clk (clk),
        .cen (mem_cen),
        .wen (mem_wen),
        .a   (mem_a),
        .d   (sram_d),
        .q   (q)
    );

    weight_cntl #(
        .MULT_PER_PE (MULT_PER_PE),
        .MAX_FV_NUM  (MAX_FV_NUM),
        .MAX_LAYERS  (MAX_LAYERS)
    ) u_cntl (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .num_layers_m1 (num_layers_m1),
        .num_fv        (num_fv),
        .q             (q),
        .cen           (cntl_cen),
        .a             (cntl_a),
        .busy          (busy),
        .lane_valid    (lane_valid),
        .lanes         (lanes),
        .fv_base       (fv_base),
        .layer         (layer),
        .sol           (sol),
        .eol           (eol),
        .last          (last)
    );

    vertex_mac #(
        .MULT_PER_PE (MULT_PER_PE),
        .MAX_FV_NUM  (MAX_FV_NUM),
        .MAX_LAYERS  (MAX_LAYERS)
    ) u_mac (
        .clk        (clk),
        .reset      (reset),
        .lane_valid (lane_valid),
        .lanes      (lanes),
        .fv_base    (fv_base),
        .layer      (layer),
        .sol        (sol),
        .eol        (eol),
        .last       (last),
        .feat       (feat),
        .res_valid  (res_valid),
        .res_layer  (res_layer),
        .res_sum    (res_sum),
        .res_last   (res_last)
    );

    result_buffer #(
        .MAX_LAYERS (MAX_LAYERS)
    ) u_results (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .res_valid (res_valid),
        .res_layer (res_layer),
        .res_sum   (res_sum),
        .res_last  (res_last),
        .results   (results),
        .done      (done)
    );

endmodule

// File: gnn_wb_pkg.sv
package gnn_wb_pkg;

    // word addressed bus
    localparam int WB_AW = 8;
    localparam int WB_DW = 32;

    // write bit0 starts a run, read bit0 busy and bit1 done
    localparam logic [WB_AW-1:0] ADR_CTRL = 8'h00;

    // bits 1:0 layers minus one, bits 12:8 feature count
    localparam logic [WB_AW-1:0] ADR_CFG = 8'h01;

    // feature i at base + i
    localparam logic [WB_AW-1:0] ADR_FEAT = 8'h10;

    // bits 4:1 line, bit0 selects the half
    localparam logic [WB_AW-1:0] ADR_WGT = 8'h40;

    // one sum per layer
    localparam logic [WB_AW-1:0] ADR_RES = 8'h80;

endpackage

// File: result_buffer.sv
module result_buffer
    import gnn_arith_pkg::*;
#(
    parameter int MAX_LAYERS = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  logic                             res_valid,
    input  logic [$clog2(MAX_LAYERS)-1:0]    res_layer,
    input  logic [ACC_W-1:0]                 res_sum,
    input  logic                             res_last,
    output logic [MAX_LAYERS-1:0][ACC_W-1:0] results,
    output logic                             done
);

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b0;
        end else if (res_last) begin
            done <= 1'b1;
        end
    end

    // a new run starts from a clean table
    always_ff @(posedge clk) begin
        if (start) begin
            results <= '0;
        end else if (res_valid) begin
            results[res_layer] <= res_sum;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f \
    --top-module tb_gnn_vertex -o tb_gnn_vertex
./obj_dir/tb_gnn_vertex > sim.log
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
grep -q "STATUS: PASS" sim.log

// File: sources.f
gnn_arith_pkg.sv
gnn_wb_pkg.sv
weight_sram.sv
wb_cfg_slave.sv
weight_cntl.sv
vertex_mac.sv
result_buffer.sv
gnn_vertex_top.sv
tb_gnn_vertex.sv

// File: tb_gnn_vertex.sv
module tb_gnn_vertex
    import gnn_arith_pkg::*, gnn_wb_pkg::*;
();

    localparam int TRACE_WORDS = 768;
    localparam int TIMEOUT     = 200;

    logic             clk;
    logic             reset;
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat_w;
    logic [WB_DW-1:0] dat_r;
    logic             ack;

    // each record holds an op, an address and a data word
    logic [31:0] trace_mem [TRACE_WORDS];

    int unsigned cycle_cnt;
    int          errors;
    int          checks;
    int          tests;
    logic        aborted;

    gnn_vertex_top #(
        .MULT_PER_PE (4),
        .MAX_FV_NUM  (16),
        .MAX_LAYERS  (4)
    ) DUT (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // one Wishbone classic access driven and sampled on falling edges
    task automatic bus_cycle(input logic is_write, input logic [WB_AW-1:0] addr,
                             input logic [WB_DW-1:0] wdata,
                             output logic [WB_DW-1:0] rdata, output int waited);
        int   gap;
        logic got;
        gap = $urandom % 4;
        repeat (gap) @(negedge clk);
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = is_write;
        adr    = addr;
        dat_w  = wdata;
        rdata  = '0;
        waited = 0;
        got    = 1'b0;
        while (!aborted && !got) begin
            @(negedge clk);
            waited++;
            if (ack) begin
                rdata = dat_r;
                got   = 1'b1;
            end else if (waited >= TIMEOUT) begin
                $display("timeout: no ack within %0d cycles for address 0x%h", TIMEOUT, addr);
                aborted = 1'b1;
                errors++;
            end
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    // poll the CTRL register until done is set
    task automatic wait_done();
        logic [WB_DW-1:0] status;
        int               waited;
        int unsigned      t0;
        logic             seen;
        t0   = cycle_cnt;
        seen = 1'b0;
        while (!aborted && !seen) begin
            bus_cycle(1'b0, ADR_CTRL, '0, status, waited);
            seen = status[1];
            if (!seen && cycle_cnt - t0 > TIMEOUT) begin
                $display("timeout: done did not rise within %0d cycles", TIMEOUT);
                aborted = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic check_result(input string name, input logic [ACC_W-1:0] got,
                                input logic [ACC_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input logic [1:0] got,
                                input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [WB_DW-1:0] got,
                             input logic [WB_DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    initial begin
        int               pc;
        int               waited;
        int               err_mark;
        logic [31:0]      op;
        logic [WB_AW-1:0] addr;
        logic [31:0]      data;
        logic [WB_DW-1:0] rd;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        reset     = 1'b1;
        cycle_cnt = 0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        err_mark  = 0;
        aborted   = 1'b0;
        void'($urandom(32'h10f7_1754));
        for (int i = 0; i < TRACE_WORDS; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("gnn_trace.txt", trace_mem);

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        pc = 0;
        op = trace_mem[0];
        while (!aborted && op != 0 && pc + 2 < TRACE_WORDS) begin
            addr = trace_mem[pc + 1][WB_AW-1:0];
            data = trace_mem[pc + 2];
            case (op)
                1: bus_cycle(1'b1, addr, data, rd, waited);
                2: begin
                    bus_cycle(1'b0, addr, '0, rd, waited);
                    check_result($sformatf("result[%0d]", addr - ADR_RES), rd, data);
                end
                3: begin
                    bus_cycle(1'b0, addr, '0, rd, waited);
                    check_status("status", rd[1:0], data[1:0]);
                end
                4: begin
                    bus_cycle(1'b0, addr, '0, rd, waited);
                    check_reg($sformatf("reg 0x%h", addr), rd, data);
                end
                5: wait_done();
                6: begin
                    tests++;
                    if (errors == err_mark) begin
                        $display("test %0d: pass", data);
                    end else begin
                        $display("test %0d: fail, %0d errors", data, errors - err_mark);
                    end
                    err_mark = errors;
                end
                // a normal access is acked within two cycles
                7: begin
                    bus_cycle(1'b1, addr, data, rd, waited);
                    checks++;
                    if (!aborted && waited <= 2) begin
                        errors++;
                        $display("weight write to 0x%h was acked during a run", addr);
                    end
                end
                default: begin
                    $display("unknown trace op %0d at word %0d", op, pc);
                    aborted = 1'b1;
                    errors++;
                end
            endcase
            pc += 3;
            op = trace_mem[pc];
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: vertex_mac.sv
module vertex_mac
    import gnn_arith_pkg::*;
#(
    parameter int MULT_PER_PE = 4,
    parameter int MAX_FV_NUM  = 16,
    parameter int MAX_LAYERS  = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  lane_valid,
    input  logic [MULT_PER_PE-1:0][FV_W-1:0]      lanes,
    input  logic [$clog2(MAX_FV_NUM)-1:0]         fv_base,
    input  logic [$clog2(MAX_LAYERS)-1:0]         layer,
    input  logic                                  sol,
    input  logic                                  eol,
    input  logic                                  last,
    input  logic [MAX_FV_NUM-1:0][FV_W-1:0]       feat,
    output logic                                  res_valid,
    output logic [$clog2(MAX_LAYERS)-1:0]         res_layer,
    output logic [ACC_W-1:0]                      res_sum,
    output logic                                  res_last
);

    localparam int FI_W = $clog2(MAX_FV_NUM);

    logic signed [ACC_W-1:0] prod [MULT_PER_PE];
    logic        [ACC_W-1:0] line_sum;
    logic        [ACC_W-1:0] acc;

    // four signed products of one line summed modulo 2^32
    always_comb begin
        line_sum = '0;
        for (int i = 0; i < MULT_PER_PE; i++) begin
            prod[i]  = $signed(lanes[i]) * $signed(feat[fv_base + FI_W'(i)]);
            line_sum = line_sum + prod[i];
        end
    end

    always_ff @(posedge clk) begin
        if (lane_valid) begin
            acc <= sol ? line_sum : acc + line_sum;
        end
        if (lane_valid && eol) begin
            res_layer <= layer;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
            res_last  <= 1'b0;
        end else begin
            res_valid <= lane_valid && eol;
            res_last  <= lane_valid && last;
        end
    end

    // acc holds the finished layer sum while res_valid is high
    assign res_sum = acc;

endmodule

// File: wb_cfg_slave.sv
module wb_cfg_slave
    import gnn_arith_pkg::*, gnn_wb_pkg::*;
#(
    parameter int MULT_PER_PE = 4,
    parameter int MAX_FV_NUM  = 16,
    parameter int MAX_LAYERS  = 4
) (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  cyc,
    input  logic                                                  stb,
    input  logic                                                  we,
    input  logic [WB_AW-1:0]                                      adr,
    input  logic [WB_DW-1:0]                                      dat_w,
    input  logic                                                  busy,
    input  logic                                                  done,
    input  logic [MAX_LAYERS-1:0][ACC_W-1:0]                      results,
    output logic [WB_DW-1:0]                                      dat_r,
    output logic                                                  ack,
    output logic                                                  start,
    output logic [$clog2(MAX_LAYERS)-1:0]                         num_layers_m1,
    output logic [$clog2(MAX_FV_NUM):0]                           num_fv,
    output logic [MAX_FV_NUM-1:0][FV_W-1:0]                       feat,
    output logic                                                  sram_we,
    output logic [$clog2(MAX_LAYERS*MAX_FV_NUM/MULT_PER_PE)-1:0] sram_a,
    output logic [LINE_W-1:0]                                     sram_d
);

    localparam int DEPTH   = MAX_LAYERS * MAX_FV_NUM / MULT_PER_PE;
    localparam int SRAM_AW = $clog2(DEPTH);
    localparam int LAYER_W = $clog2(MAX_LAYERS);
    localparam int FVN_W   = $clog2(MAX_FV_NUM) + 1;
    localparam int FI_W    = $clog2(MAX_FV_NUM);

    logic                    is_ctrl;
    logic                    is_cfg;
    logic                    is_feat;
    logic                    is_wgt;
    logic                    is_res;
    logic                    req;
    logic                    hold;
    logic                    accept;
    logic                    wr;
    logic [LINE_W-WB_DW-1:0] wgt_lo;
    logic [WB_DW-1:0]        rd_data;

    assign is_ctrl = adr == ADR_CTRL;
    assign is_cfg  = adr == ADR_CFG;
    assign is_feat = adr >= ADR_FEAT && adr < ADR_FEAT + MAX_FV_NUM;
    assign is_wgt  = adr >= ADR_WGT && adr < ADR_WGT + 2 * DEPTH;
    assign is_res  = adr >= ADR_RES && adr < ADR_RES + MAX_LAYERS;

    // pending request other than the one acked this cycle
    assign req = cyc && stb && !ack;

    // controller owns the SRAM and the MAC reads the features during a run
    assign hold   = busy && we && (is_feat || is_wgt);
    assign accept = req && !hold;
    assign wr     = accept && we;

    // odd half commits the staged low word with the bus word
    assign sram_we = wr && is_wgt && adr[0];
    assign sram_a  = adr[SRAM_AW:1];
    assign sram_d  = {dat_w, wgt_lo};

    always_comb begin
        rd_data = '0;
        if (is_ctrl) begin
            rd_data[1:0] = {done, busy};
        end else if (is_cfg) begin
            rd_data[LAYER_W-1:0] = num_layers_m1;
            rd_data[8 +: FVN_W]  = num_fv;
        end else if (is_feat) begin
            rd_data[FV_W-1:0] = feat[adr[FI_W-1:0]];
        end else if (is_res) begin
            rd_data = results[adr[LAYER_W-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack           <= 1'b0;
            start         <= 1'b0;
            num_layers_m1 <= '0;
            num_fv        <= '0;
        end else begin
            ack   <= accept;
            // a second start during a run is dropped
            start <= wr && is_ctrl && dat_w[0] && !busy;
            if (wr && is_cfg) begin
                num_layers_m1 <= dat_w[LAYER_W-1:0];
                num_fv        <= dat_w[8 +: FVN_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dat_r <= rd_data;
        end
        if (wr && is_feat) begin
            feat[adr[FI_W-1:0]] <= dat_w[FV_W-1:0];
        end
        if (wr && is_wgt && !adr[0]) begin
            wgt_lo <= dat_w;
        end
    end

endmodule

// File: weight_cntl.sv
module weight_cntl
    import gnn_arith_pkg::*;
#(
    parameter int MULT_PER_PE = 4,
    parameter int MAX_FV_NUM  = 16,
    parameter int MAX_LAYERS  = 4
) (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  start,
    input  logic [$clog2(MAX_LAYERS)-1:0]                         num_layers_m1,
    input  logic [$clog2(MAX_FV_NUM):0]                           num_fv,
    input  logic [LINE_W-1:0]                                     q,
    output logic                                                  cen,
    output logic [$clog2(MAX_LAYERS*MAX_FV_NUM/MULT_PER_PE)-1:0] a,
    output logic                                                  busy,
    output logic                                                  lane_valid,
    output logic [MULT_PER_PE-1:0][FV_W-1:0]                      lanes,
    output logic [$clog2(MAX_FV_NUM)-1:0]                         fv_base,
    output logic [$clog2(MAX_LAYERS)-1:0]                         layer,
    output logic                                                  sol,
    output logic                                                  eol,
    output logic                                                  last
);

    localparam int LINE_AW = $clog2(MAX_FV_NUM / MULT_PER_PE);
    localparam int LAYER_W = $clog2(MAX_LAYERS);
    localparam int FVN_W   = $clog2(MAX_FV_NUM) + 1;
    localparam int FI_W    = $clog2(MAX_FV_NUM);

    localparam logic IDLE = 1'b0;
    localparam logic WORK = 1'b1;

    logic               state;
    logic [LINE_AW-1:0] line_cnt;
    logic [LAYER_W-1:0] layer_cnt;
    logic [FI_W-1:0]    fv_cur;
    logic               line_end;
    logic               last_layer;

    // markers of the read in flight line up with q
    logic               s1_valid;
    logic [FI_W-1:0]    s1_fv_base;
    logic [LAYER_W-1:0] s1_layer;
    logic               s1_sol;
    logic               s1_eol;
    logic               s1_last;

    assign busy       = state == WORK;
    assign cen        = !busy;
    assign a          = {layer_cnt, line_cnt};
    assign fv_cur     = FI_W'(line_cnt) * FI_W'(MULT_PER_PE);
    assign line_end   = FVN_W'(fv_cur) + FVN_W'(MULT_PER_PE) == num_fv;
    assign last_layer = layer_cnt == num_layers_m1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            line_cnt  <= '0;
            layer_cnt <= '0;
        end else if (state == IDLE) begin
            if (start) begin
                state <= WORK;
            end
        end else if (line_end) begin
            line_cnt <= '0;
            if (last_layer) begin
                // counters are left at zero for the next run
                state     <= IDLE;
                layer_cnt <= '0;
            end else begin
                layer_cnt <= layer_cnt + 1'b1;
            end
        end else begin
            line_cnt <= line_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid   <= 1'b0;
            s1_sol     <= 1'b0;
            s1_eol     <= 1'b0;
            s1_last    <= 1'b0;
            lane_valid <= 1'b0;
            sol        <= 1'b0;
            eol        <= 1'b0;
            last       <= 1'b0;
        end else begin
            s1_valid   <= busy;
            s1_sol     <= busy && line_cnt == '0;
            s1_eol     <= busy && line_end;
            s1_last    <= busy && line_end && last_layer;
            lane_valid <= s1_valid;
            sol        <= s1_sol;
            eol        <= s1_eol;
            last       <= s1_last;
        end
    end

    always_ff @(posedge clk) begin
        s1_fv_base <= fv_cur;
        s1_layer   <= layer_cnt;
        fv_base    <= s1_fv_base;
        layer      <= s1_layer;
        // lane 0 sits in the low bits of the line
        for (int i = 0; i < MULT_PER_PE; i++) begin
            lanes[i] <= q[i*FV_W +: FV_W];
        end
    end

endmodule

// File: weight_sram.sv
module weight_sram
    import gnn_arith_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     cen,
    input  logic                     wen,
    input  logic [$clog2(DEPTH)-1:0] a,
    input  logic [LINE_W-1:0]        d,
    output logic [LINE_W-1:0]        q
);

    logic [LINE_W-1:0] mem [DEPTH];

    // cen and wen are active low
    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[a] <= d;
            end else begin
                q <= mem[a];
            end
        end
    end

endmodule
